/* Makefile */
# Verilator build and run of the jump-and-link lane testbench

TOP := tb_jal_lane

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

obj_dir/V$(TOP): build.f $(wildcard rtl/*.sv rtl/*.svh verification/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+rtl
rtl/jal_pkg.sv
rtl/phy_regfile.sv
rtl/jal_issue.sv
rtl/jal_exec.sv
rtl/jal_lane.sv
verification/tb_jal_lane.sv

/* rtl/jal_cfg.svh */
/*
 * sizing macros for the jump-and-link lane
 * include wherever widths or depths are needed
 * physical index = {arch reg[4:0], rename slot}
 * queue depth must stay a power of two
 */
`ifndef JAL_CFG_SVH
`define JAL_CFG_SVH

`define JAL_XLEN    64                // data and pc width
`define JAL_RB      2                 // rename bits per arch register
`define JAL_PRW     (5 + `JAL_RB)     // physical register index width
`define JAL_PRN     128               // number of physical registers
`define JAL_QDEPTH  4                 // issue queue entries
`define JAL_QPW     2                 // log2 of queue depth

`endif

/* rtl/jal_exec.sv */
/*
 * jump-and-link execution unit
 * link value is pc + 4, or pc + 2 for compressed encodings
 * JALR also produces a redirect to (rs1 + imm) with bit 0 cleared
 * all outputs are registered, one cycle after issue
 * flush on the issue edge suppresses the redirect strobe
 */
`timescale 1ns/1ps
`include "jal_cfg.svh"

module jal_exec (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 flush,

	input  logic                 issue_valid,
	input  jal_pkg::jal_op_e     issue_op,
	input  logic [`JAL_PRW-1:0]  issue_rd0,
	input  logic [`JAL_XLEN-1:0] issue_src1,
	input  logic [`JAL_XLEN-1:0] issue_pc,
	input  logic [`JAL_XLEN-1:0] issue_imm,
	input  logic                 issue_rvc,

	output logic                 wb_valid,         // to regfile and outside
	output logic [`JAL_PRW-1:0]  wb_rd0,
	output logic [`JAL_XLEN-1:0] wb_res,
	output logic                 redirect_valid,   // to frontend
	output logic [`JAL_XLEN-1:0] redirect_pc
);

	import jal_pkg::*;

	logic [`JAL_XLEN-1:0] link_dnxt;
	logic [`JAL_XLEN-1:0] target_dnxt;
	logic                 redirect_dnxt;

	assign link_dnxt     = issue_pc + (issue_rvc ? `JAL_XLEN'd2 : `JAL_XLEN'd4);
	assign target_dnxt   = (issue_src1 + issue_imm) & ~`JAL_XLEN'd1; // lsb forced to 0
	assign redirect_dnxt = issue_valid & (issue_op == OP_JALR) & ~flush;

	// strobes
	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid       <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			wb_valid       <= issue_valid;          // writeback completes even under flush
			redirect_valid <= redirect_dnxt;
		end
	end

	// payload, held between issues
	always_ff @(posedge CLK) begin
		if (issue_valid) begin
			wb_rd0      <= issue_rd0;
			wb_res      <= link_dnxt;
			redirect_pc <= target_dnxt;            // only meaningful with redirect_valid
		end
	end

	// a redirect never shows up without its link writeback
	assert property (@(posedge CLK) disable iff (rst)
		redirect_valid |-> wb_valid)
		else $error("redirect without writeback");

endmodule

/* rtl/jal_issue.sv */
/*
 * in-order issue queue for JAL/JALR
 * dispatch pushes at the tail, only the head is ever examined
 * a JALR head waits on its rs1 ready bit, a JAL issues as soon as it is head
 * flush empties the queue and holds off issue while high
 */
`timescale 1ns/1ps
`include "jal_cfg.svh"

module jal_issue (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 flush,

	input  logic                 dispatch_valid,   // strobe, only while not full
	input  jal_pkg::jal_op_e     dispatch_op,
	input  logic [`JAL_PRW-1:0]  dispatch_rd0,
	input  logic [`JAL_PRW-1:0]  dispatch_rs1,
	input  logic [`JAL_XLEN-1:0] dispatch_pc,
	input  logic [`JAL_XLEN-1:0] dispatch_imm,
	input  logic                 dispatch_rvc,
	output logic                 issue_full,

	output logic [`JAL_PRW-1:0]  rd_idx,           // to regfile read port
	input  logic [`JAL_XLEN-1:0] rd_data,
	input  logic                 rd_ready,

	output logic                 issue_valid,
	output jal_pkg::jal_op_e     issue_op,
	output logic [`JAL_PRW-1:0]  issue_rd0,
	output logic [`JAL_XLEN-1:0] issue_src1,
	output logic [`JAL_XLEN-1:0] issue_pc,
	output logic [`JAL_XLEN-1:0] issue_imm,
	output logic                 issue_rvc
);

	import jal_pkg::*;

	// queue payload
	jal_op_e              q_op  [`JAL_QDEPTH];
	logic [`JAL_PRW-1:0]  q_rd0 [`JAL_QDEPTH];
	logic [`JAL_PRW-1:0]  q_rs1 [`JAL_QDEPTH];
	logic [`JAL_XLEN-1:0] q_pc  [`JAL_QDEPTH];
	logic [`JAL_XLEN-1:0] q_imm [`JAL_QDEPTH];
	logic                 q_rvc [`JAL_QDEPTH];

	logic [`JAL_QPW-1:0] head;
	logic [`JAL_QPW-1:0] tail;
	logic [`JAL_QPW-1:0] head_nxt;
	logic [`JAL_QPW-1:0] tail_nxt;
	q_state_e            state;

	logic push;
	logic pop;
	logic head_ready;

	assign push     = dispatch_valid;
	assign pop      = issue_valid;
	assign head_nxt = head + 1'b1;             // pointers wrap, depth is a power of two
	assign tail_nxt = tail + 1'b1;

	assign issue_full = (state == Q_FULL);

	// head lookup, src read goes straight to the regfile
	assign rd_idx     = q_rs1[head];
	assign head_ready = (q_op[head] == OP_JAL) | rd_ready; // JAL has no source
	assign issue_valid = (state != Q_EMPTY) & head_ready & ~flush;

	assign issue_op   = q_op[head];
	assign issue_rd0  = q_rd0[head];
	assign issue_src1 = rd_data;
	assign issue_pc   = q_pc[head];
	assign issue_imm  = q_imm[head];
	assign issue_rvc  = q_rvc[head];

	// pointers and occupancy
	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			head  <= '0;
			tail  <= '0;
			state <= Q_EMPTY;                      // flush drops everything queued
		end else begin
			if (push) begin
				tail <= tail_nxt;
			end
			if (pop) begin
				head <= head_nxt;
			end
			if (push && !pop) begin
				state <= (tail_nxt == head) ? Q_FULL : Q_PARTIAL;
			end else if (pop && !push) begin
				state <= (head_nxt == tail) ? Q_EMPTY : Q_PARTIAL;
			end
		end
	end

	// entry payload, written at the tail
	always_ff @(posedge CLK) begin
		if (push) begin
			q_op[tail]  <= dispatch_op;
			q_rd0[tail] <= dispatch_rd0;
			q_rs1[tail] <= dispatch_rs1;
			q_pc[tail]  <= dispatch_pc;
			q_imm[tail] <= dispatch_imm;
			q_rvc[tail] <= dispatch_rvc;
		end
	end

	// dispatcher must watch issue_full
	assert property (@(posedge CLK) disable iff (rst)
		dispatch_valid |-> state != Q_FULL)
		else $error("dispatch while issue queue full");

	// a live head entry means the pointers differ unless the queue is full
	assert property (@(posedge CLK) disable iff (rst)
		issue_valid |-> (head != tail) || (state == Q_FULL))
		else $error("issue from an empty queue");

endmodule

/* rtl/jal_lane.sv */
/*
 * top of the jump-and-link lane
 * dispatch -> issue queue -> exec, with the physical regfile beside them
 * lane writebacks and the external port both set ready bits
 * dispatcher holds dispatch_valid low while issue_full is high
 */
`timescale 1ns/1ps
`include "jal_cfg.svh"

module jal_lane (
	input  logic                 CLK,
	input  logic                 rst,
	input  logic                 flush,            // level, empties queue

	input  logic                 dispatch_valid,
	input  jal_pkg::jal_op_e     dispatch_op,
	input  logic [`JAL_PRW-1:0]  dispatch_rd0,
	input  logic [`JAL_PRW-1:0]  dispatch_rs1,
	input  logic [`JAL_XLEN-1:0] dispatch_pc,
	input  logic [`JAL_XLEN-1:0] dispatch_imm,
	input  logic                 dispatch_rvc,
	output logic                 issue_full,

	input  logic                 ext_wb_valid,     // writes from other units
	input  logic [`JAL_PRW-1:0]  ext_wb_rd0,
	input  logic [`JAL_XLEN-1:0] ext_wb_data,

	output logic                 wb_valid,
	output logic [`JAL_PRW-1:0]  wb_rd0,
	output logic [`JAL_XLEN-1:0] wb_res,
	output logic                 redirect_valid,
	output logic [`JAL_XLEN-1:0] redirect_pc
);

	import jal_pkg::*;

	// regfile read port
	logic [`JAL_PRW-1:0]  rd_idx;
	logic [`JAL_XLEN-1:0] rd_data;
	logic                 rd_ready;

	// issue to exec
	logic                 issue_valid;
	jal_op_e              issue_op;
	logic [`JAL_PRW-1:0]  issue_rd0;
	logic [`JAL_XLEN-1:0] issue_src1;
	logic [`JAL_XLEN-1:0] issue_pc;
	logic [`JAL_XLEN-1:0] issue_imm;
	logic                 issue_rvc;

	phy_regfile u_regfile (
		.CLK         (CLK),
		.rst         (rst),
		.rd_idx      (rd_idx),
		.rd_data     (rd_data),
		.rd_ready    (rd_ready),
		.wa_valid    (wb_valid),        // lane result
		.wa_idx      (wb_rd0),
		.wa_data     (wb_res),
		.wb_valid    (ext_wb_valid),    // external result
		.wb_idx      (ext_wb_rd0),
		.wb_data     (ext_wb_data),
		.alloc_valid (dispatch_valid),  // rd goes unready on dispatch
		.alloc_idx   (dispatch_rd0)
	);

	jal_issue u_issue (
		.CLK            (CLK),
		.rst            (rst),
		.flush          (flush),
		.dispatch_valid (dispatch_valid),
		.dispatch_op    (dispatch_op),
		.dispatch_rd0   (dispatch_rd0),
		.dispatch_rs1   (dispatch_rs1),
		.dispatch_pc    (dispatch_pc),
		.dispatch_imm   (dispatch_imm),
		.dispatch_rvc   (dispatch_rvc),
		.issue_full     (issue_full),
		.rd_idx         (rd_idx),
		.rd_data        (rd_data),
		.rd_ready       (rd_ready),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.issue_rd0      (issue_rd0),
		.issue_src1     (issue_src1),
		.issue_pc       (issue_pc),
		.issue_imm      (issue_imm),
		.issue_rvc      (issue_rvc)
	);

	jal_exec u_exec (
		.CLK            (CLK),
		.rst            (rst),
		.flush          (flush),
		.issue_valid    (issue_valid),
		.issue_op       (issue_op),
		.issue_rd0      (issue_rd0),
		.issue_src1     (issue_src1),
		.issue_pc       (issue_pc),
		.issue_imm      (issue_imm),
		.issue_rvc      (issue_rvc),
		.wb_valid       (wb_valid),
		.wb_rd0         (wb_rd0),
		.wb_res         (wb_res),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

/* rtl/jal_pkg.sv */
/*
 * shared types for the jump-and-link lane
 * opcode enum travels from dispatch through issue to exec
 * queue state enum tracks issue queue occupancy
 */
package jal_pkg;

	// jump opcode carried by each queue entry
	typedef enum logic {
		OP_JAL  = 1'b0,                 // pc-relative, no source
		OP_JALR = 1'b1                  // register-indirect, reads rs1
	} jal_op_e;

	// issue queue occupancy
	typedef enum logic [1:0] {
		Q_EMPTY   = 2'd0,               // nothing to issue
		Q_PARTIAL = 2'd1,               // some entries, room left
		Q_FULL    = 2'd2                // dispatch must hold off
	} q_state_e;

endpackage

/* rtl/phy_regfile.sv */
/*
 * physical register file with per-register ready bits
 * one combinational read port for the issue queue head
 * write port a takes lane writebacks, port b the external writebacks
 * alloc clears ready on dispatch, any write sets it again
 * arch register 0 slots always read zero and ready
 */
`timescale 1ns/1ps
`include "jal_cfg.svh"

module phy_regfile (
	input  logic                 CLK,
	input  logic                 rst,

	input  logic [`JAL_PRW-1:0]  rd_idx,       // head rs1
	output logic [`JAL_XLEN-1:0] rd_data,
	output logic                 rd_ready,

	input  logic                 wa_valid,     // lane writeback
	input  logic [`JAL_PRW-1:0]  wa_idx,
	input  logic [`JAL_XLEN-1:0] wa_data,

	input  logic                 wb_valid,     // external writeback
	input  logic [`JAL_PRW-1:0]  wb_idx,
	input  logic [`JAL_XLEN-1:0] wb_data,

	input  logic                 alloc_valid,  // dispatch of a new rd
	input  logic [`JAL_PRW-1:0]  alloc_idx
);

	logic [`JAL_XLEN-1:0] regs [`JAL_PRN];   // register values
	logic [`JAL_PRN-1:0]  ready;             // one ready bit per register

	logic rd_x0;
	logic wa_en;
	logic wb_en;
	logic alloc_en;

	// top 5 bits of an index are the arch register number
	function automatic logic is_x0(input logic [`JAL_PRW-1:0] idx);
		return idx[`JAL_PRW-1 -: 5] == 5'd0;
	endfunction

	assign rd_x0    = is_x0(rd_idx);
	assign wa_en    = wa_valid & ~is_x0(wa_idx);      // x0 writes dropped
	assign wb_en    = wb_valid & ~is_x0(wb_idx);
	assign alloc_en = alloc_valid & ~is_x0(alloc_idx); // x0 never goes unready

	// no bypass, a write is visible the cycle after its edge
	assign rd_data  = rd_x0 ? '0 : regs[rd_idx];
	assign rd_ready = rd_x0 | ready[rd_idx];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `JAL_PRN; i++) begin
				regs[i] <= '0;                        // all registers start at zero
			end
			ready <= '1;                              // everything ready out of reset
		end else begin
			if (alloc_en) begin
				ready[alloc_idx] <= 1'b0;             // rd pending until written
			end
			if (wb_en) begin
				regs[wb_idx]  <= wb_data;
				ready[wb_idx] <= 1'b1;
			end
			if (wa_en) begin                          // last, so lane write wins a tie
				regs[wa_idx]  <= wa_data;
				ready[wa_idx] <= 1'b1;
			end
		end
	end

	// a freshly allocated rd cannot already be in flight to a write port
	assert property (@(posedge CLK) disable iff (rst)
		alloc_en |-> !(wa_en && wa_idx == alloc_idx) && !(wb_en && wb_idx == alloc_idx))
		else $error("alloc of p%0d collides with a write on the same edge", alloc_idx);

endmodule

/* verification/tb_jal_lane.sv */
/*
 * directed testbench for the jump-and-link lane
 * tests drive dispatch, flush and external writebacks on falling edges
 * a scoreboard on the rising edge keeps a model of ready bits, register
 * values and the in-order queue, and checks every lane writeback
 */
`timescale 1ns/1ps
`include "jal_cfg.svh"

module tb_jal_lane;

	import jal_pkg::*;

	localparam int TEST_CYCLES = 120;   // reset plus all tests, with slack
	localparam int WB_BOUND    = 20;    // cycles allowed for one awaited writeback

	// dispatched op waiting for its writeback
	typedef struct packed {
		jal_op_e              op;
		logic [`JAL_PRW-1:0]  rd0;
		logic [`JAL_PRW-1:0]  rs1;
		logic [`JAL_XLEN-1:0] pc;
		logic [`JAL_XLEN-1:0] imm;
		logic                 rvc;
	} pend_t;

	logic                 CLK;
	logic                 rst;
	logic                 flush;
	logic                 dispatch_valid;
	jal_op_e              dispatch_op;
	logic [`JAL_PRW-1:0]  dispatch_rd0;
	logic [`JAL_PRW-1:0]  dispatch_rs1;
	logic [`JAL_XLEN-1:0] dispatch_pc;
	logic [`JAL_XLEN-1:0] dispatch_imm;
	logic                 dispatch_rvc;
	logic                 issue_full;
	logic                 ext_wb_valid;
	logic [`JAL_PRW-1:0]  ext_wb_rd0;
	logic [`JAL_XLEN-1:0] ext_wb_data;
	logic                 wb_valid;
	logic [`JAL_PRW-1:0]  wb_rd0;
	logic [`JAL_XLEN-1:0] wb_res;
	logic                 redirect_valid;
	logic [`JAL_XLEN-1:0] redirect_pc;

	logic [`JAL_XLEN-1:0] model_val [`JAL_PRN];   // expected register values
	logic                 model_ready [`JAL_PRN]; // expected ready bits
	pend_t                pending [$];            // oldest op at the front
	int                   wb_seen;                // lane writebacks checked so far
	logic [63:0]          rng = 64'd57;           // xorshift state

	jal_lane dut (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		#(TEST_CYCLES * 10 * 4);
		$display("watchdog expired after %0d ns, tests did not finish", TEST_CYCLES * 40);
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog");
	end

	function automatic logic [63:0] xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 7);
		rng = rng ^ (rng << 17);
		return rng;
	endfunction

	function automatic logic [`JAL_XLEN-1:0] rand_pc();
		return xorshift() & ~`JAL_XLEN'(1);      // instructions sit on halfwords
	endfunction

	function automatic logic [`JAL_XLEN-1:0] rand_imm();
		logic [63:0] r;
		r = xorshift();
		return {{52{r[11]}}, r[11:0]};          // sign-extended 12-bit offset
	endfunction

	function automatic logic [4:0] arch_of(input logic [`JAL_PRW-1:0] idx);
		return idx[`JAL_PRW-1:`JAL_RB];
	endfunction

	function automatic logic [`JAL_XLEN-1:0] model_read(input logic [`JAL_PRW-1:0] idx);
		return (arch_of(idx) == 5'd0) ? '0 : model_val[idx];
	endfunction

	task automatic abort(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			abort($sformatf("Mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp));
		end
	endtask

	// compare one lane writeback with the oldest pending op
	task automatic score_wb(output logic [`JAL_PRW-1:0] rd0, output logic [`JAL_XLEN-1:0] link);
		pend_t                e;
		logic [`JAL_XLEN-1:0] target;
		if (pending.size() == 0) begin
			abort($sformatf("writeback at %0t with no operation outstanding", $time));
		end else begin
			e = pending.pop_front();
			link = e.pc + (e.rvc ? `JAL_XLEN'(2) : `JAL_XLEN'(4));
			rd0 = e.rd0;
			check("wb_rd0", 64'(wb_rd0), 64'(e.rd0));   // also proves in-order issue
			check("wb_res", wb_res, link);
			check("redirect_valid", 64'(redirect_valid), 64'(e.op == OP_JALR));
			if (e.op == OP_JALR) begin
				check("rs1 ready before issue", 64'(model_ready[e.rs1]), 64'd1);
				target = (model_read(e.rs1) + e.imm) & ~`JAL_XLEN'(1);
				check("redirect_pc", redirect_pc, target);
			end
			wb_seen++;
		end
	endtask

	// apply this edge's writes, allocation and queue change to the model
	task automatic update_model(input logic lane_wr, input logic [`JAL_PRW-1:0] lane_rd,
			input logic [`JAL_XLEN-1:0] lane_link);
		if (dispatch_valid && arch_of(dispatch_rd0) != 5'd0) begin
			model_ready[dispatch_rd0] = 1'b0;         // pending until written
		end
		if (ext_wb_valid && arch_of(ext_wb_rd0) != 5'd0) begin
			model_val[ext_wb_rd0]   = ext_wb_data;
			model_ready[ext_wb_rd0] = 1'b1;
		end
		if (lane_wr && arch_of(lane_rd) != 5'd0) begin   // after ext so lane wins a tie
			model_val[lane_rd]   = lane_link;
			model_ready[lane_rd] = 1'b1;
		end
		if (flush) begin
			pending.delete();                         // nothing issues in a flush cycle
		end else if (dispatch_valid) begin
			pending.push_back({dispatch_op, dispatch_rd0, dispatch_rs1,
				dispatch_pc, dispatch_imm, dispatch_rvc});
		end
	endtask

	always @(posedge CLK) begin : scoreboard
		logic                 lane_wr;
		logic [`JAL_PRW-1:0]  lane_rd;
		logic [`JAL_XLEN-1:0] lane_link;
		lane_wr = 1'b0;
		if (rst) begin
			for (int i = 0; i < `JAL_PRN; i++) begin
				model_val[i]   = '0;
				model_ready[i] = 1'b1;
			end
			pending.delete();
			wb_seen = 0;
		end else begin
			if (wb_valid) begin
				score_wb(lane_rd, lane_link);           // sees state before this edge
				lane_wr = 1'b1;
			end else if (redirect_valid) begin
				abort($sformatf("redirect_valid without wb_valid at %0t", $time));
			end
			update_model(lane_wr, lane_rd, lane_link);
		end
	end

	task automatic idle(input int n);
		repeat (n) @(negedge CLK);
	endtask

	task automatic dispatch(input jal_op_e op, input logic [`JAL_PRW-1:0] rd0,
			input logic [`JAL_PRW-1:0] rs1, input logic [`JAL_XLEN-1:0] pc,
			input logic [`JAL_XLEN-1:0] imm, input logic rvc);
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_rd0   = rd0;
		dispatch_rs1   = rs1;
		dispatch_pc    = pc;
		dispatch_imm   = imm;
		dispatch_rvc   = rvc;
		@(negedge CLK);
		dispatch_valid = 1'b0;
	endtask

	task automatic ext_write(input logic [`JAL_PRW-1:0] idx, input logic [`JAL_XLEN-1:0] data);
		ext_wb_valid = 1'b1;
		ext_wb_rd0   = idx;
		ext_wb_data  = data;
		@(negedge CLK);
		ext_wb_valid = 1'b0;
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(negedge CLK);
		flush = 1'b0;
	endtask

	// wait until the scoreboard has checked target writebacks in total
	task automatic wait_wb(input int target, output int cycles);
		cycles = 0;
		while (wb_seen < target) begin
			if (cycles == WB_BOUND) begin
				abort($sformatf("writeback never arrived, %0d of %0d seen after %0d cycles",
					wb_seen, target, cycles));
			end else begin
				@(negedge CLK);
				cycles++;
			end
		end
	endtask

	task automatic expect_quiet(input int n, input string what);
		int base;
		base = wb_seen;
		idle(n);
		check(what, 64'(wb_seen), 64'(base));
	endtask

	task automatic test_jal_link();
		int base;
		int lat;
		for (int i = 0; i < 2; i++) begin           // i = 1 is the compressed form
			base = wb_seen;
			dispatch(OP_JAL, {5'd5, 2'(i)}, '0, rand_pc(), rand_imm(), i[0]);
			wait_wb(base + 1, lat);
			check("JAL dispatch-to-writeback cycles", 64'(lat), 64'd2);
		end
	endtask

	task automatic test_jalr_target();
		int base;
		int lat;
		ext_write({5'd7, 2'd0}, xorshift());
		for (int i = 0; i < 2; i++) begin
			base = wb_seen;
			dispatch(OP_JALR, {5'd1, 2'(i)}, {5'd7, 2'd0}, rand_pc(), rand_imm(), i[0]);
			wait_wb(base + 1, lat);
			check("JALR dispatch-to-writeback cycles", 64'(lat), 64'd2);
		end
	endtask

	task automatic test_dep_wait();
		int base;
		int lat;
		base = wb_seen;
		// rd doubles as the source, only the external port can release it
		dispatch(OP_JALR, {5'd10, 2'd3}, {5'd10, 2'd3}, rand_pc(), rand_imm(), 1'b0);
		expect_quiet(6, "writebacks while the source is pending");
		ext_write({5'd10, 2'd3}, xorshift());
		wait_wb(base + 1, lat);
		check("source write to writeback cycles", 64'(lat), 64'd2);
	endtask

	task automatic test_chain();
		int base;
		int lat;
		base = wb_seen;
		dispatch(OP_JAL, {5'd11, 2'd0}, '0, rand_pc(), rand_imm(), 1'b0);
		dispatch(OP_JALR, {5'd12, 2'd0}, {5'd11, 2'd0}, rand_pc(), rand_imm(), 1'b0);
		dispatch(OP_JAL, {5'd13, 2'd0}, '0, rand_pc(), rand_imm(), 1'b1);   // stuck behind JALR
		wait_wb(base + 3, lat);
	endtask

	task automatic test_full_flush();
		int base;
		dispatch(OP_JALR, {5'd20, 2'd1}, {5'd20, 2'd1}, rand_pc(), rand_imm(), 1'b0);
		for (int i = 0; i < 3; i++) begin
			check("issue_full while filling", 64'(issue_full), 64'd0);
			dispatch(OP_JAL, {5'd21, 2'(i)}, '0, rand_pc(), rand_imm(), 1'b0);
		end
		check("issue_full with four entries", 64'(issue_full), 64'd1);
		pulse_flush();
		check("issue_full after flush", 64'(issue_full), 64'd0);
		ext_write({5'd20, 2'd1}, xorshift());   // would release the old head if it survived
		expect_quiet(6, "writebacks after flushing a full queue");
		// flush on the cycle a ready JALR would issue drops it
		dispatch(OP_JALR, {5'd22, 2'd0}, {5'd7, 2'd0}, rand_pc(), rand_imm(), 1'b0);
		pulse_flush();
		expect_quiet(6, "writebacks after flushing at issue");
		// first JALR is already in exec when flush rises, the second is not
		base = wb_seen;
		dispatch(OP_JALR, {5'd23, 2'd0}, {5'd7, 2'd0}, rand_pc(), rand_imm(), 1'b0);
		dispatch(OP_JALR, {5'd24, 2'd0}, {5'd7, 2'd0}, rand_pc(), rand_imm(), 1'b0);
		pulse_flush();
		idle(6);
		check("writebacks across flush with one op in flight", 64'(wb_seen), 64'(base + 1));
	endtask

	task automatic test_x0();
		int base;
		int lat;
		base = wb_seen;
		dispatch(OP_JALR, {5'd14, 2'd0}, {5'd0, 2'd2}, rand_pc(), rand_imm(), 1'b0);
		wait_wb(base + 1, lat);
		check("JALR on x0 dispatch-to-writeback cycles", 64'(lat), 64'd2);
		ext_write({5'd0, 2'd1}, xorshift());            // dropped by the regfile
		dispatch(OP_JAL, {5'd0, 2'd3}, '0, rand_pc(), rand_imm(), 1'b0);
		wait_wb(base + 2, lat);
		dispatch(OP_JALR, {5'd15, 2'd0}, {5'd0, 2'd1}, rand_pc(), rand_imm(), 1'b0);
		dispatch(OP_JALR, {5'd15, 2'd1}, {5'd0, 2'd3}, rand_pc(), rand_imm(), 1'b1);
		wait_wb(base + 4, lat);
	endtask

	initial begin
		rst            = 1'b1;
		flush          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op    = OP_JAL;
		dispatch_rd0   = '0;
		dispatch_rs1   = '0;
		dispatch_pc    = '0;
		dispatch_imm   = '0;
		dispatch_rvc   = 1'b0;
		ext_wb_valid   = 1'b0;
		ext_wb_rd0     = '0;
		ext_wb_data    = '0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		check("wb_valid after reset", 64'(wb_valid), 64'd0);
		check("redirect_valid after reset", 64'(redirect_valid), 64'd0);
		check("issue_full after reset", 64'(issue_full), 64'd0);
		test_jal_link();
		test_jalr_target();
		test_dep_wait();
		test_chain();
		test_full_flush();
		test_x0();
		idle(4);
		check("ops left without writeback", 64'(pending.size()), 64'd0);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
